// ==== rtl/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// Datapath width of the RV64I integer unit
`define EX_XLEN 64

// Shift amount widths for the full and the word forms
`define EX_SHAMT_W  6
`define EX_SHAMTW_W 5

// Major opcodes, bits [6:0] of the instruction
`define EX_OPC_LOAD      7'b0000011
`define EX_OPC_OP_IMM    7'b0010011
`define EX_OPC_AUIPC     7'b0010111
`define EX_OPC_OP_IMM_32 7'b0011011
`define EX_OPC_STORE     7'b0100011
`define EX_OPC_OP        7'b0110011
`define EX_OPC_LUI       7'b0110111
`define EX_OPC_OP_32     7'b0111011

`endif

// ==== rtl/ex_pkg.sv ====
`include "ex_cfg.svh"

package ex_pkg;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10,  // LUI, the immediate is already in src2
    ALU_ZERO   = 4'd11
  } alu_op_e;

  // One issued instruction as seen by the execute stage
  typedef struct packed {
    logic [6:0]          opcode;
    logic [2:0]          func3;
    logic                func7_b30;
    logic [`EX_XLEN-1:0] src1;
    logic [`EX_XLEN-1:0] src2;  // Holds the immediate for the I and U forms
    logic [`EX_XLEN-1:0] pc;
    logic [4:0]          rd;
  } ex_req_t;

  typedef struct packed {
    logic [`EX_XLEN-1:0] result;
    logic [4:0]          rd;
  } ex_res_t;

endpackage

// ==== rtl/ex_pipe_reg.sv ====
`timescale 1ns/1ps

module ex_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic load;

  assign load = !stall && in_valid;

  // Flush wins over stall, a stalled slot keeps its valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (flush) begin
      out_valid <= 1'b0;
    end else if (!stall) begin
      out_valid <= in_valid;
    end
  end

  // Payload only moves when a real transfer happens
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_data <= '0;
    end else if (load && !flush) begin
      out_data <= in_data;
    end
  end

endmodule

// ==== rtl/alu_decode.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module alu_decode (
  input  logic            [6:0] opcode,
  input  logic            [2:0] func3,
  input  logic                  func7_b30,
  output ex_pkg::alu_op_e       op,
  output logic                  sel_pc,
  output logic                  word
);
  import ex_pkg::*;

  logic    reg_form;
  logic    word_ok;
  alu_op_e base_op;

  // Only register forms have SUB, ADDI has no subtract variant
  assign reg_form = (opcode == `EX_OPC_OP) || (opcode == `EX_OPC_OP_32);

  // The word opcodes only define ADD/SUB, SLL and SRL/SRA
  assign word_ok = (func3 == 3'b000) || (func3 == 3'b001) || (func3 == 3'b101);

  always_comb begin
    case (func3)
      3'b000: base_op = (reg_form && func7_b30) ? ALU_SUB : ALU_ADD;
      3'b001: base_op = ALU_SLL;
      3'b010: base_op = ALU_SLT;
      3'b011: base_op = ALU_SLTU;
      3'b100: base_op = ALU_XOR;
      3'b101: base_op = func7_b30 ? ALU_SRA : ALU_SRL;
      3'b110: base_op = ALU_OR;
      default: base_op = ALU_AND;
    endcase
  end

  always_comb begin
    op     = ALU_ZERO;
    sel_pc = 1'b0;
    word   = 1'b0;
    case (opcode)
      `EX_OPC_OP,
      `EX_OPC_OP_IMM: begin
        op = base_op;
      end
      `EX_OPC_OP_32,
      `EX_OPC_OP_IMM_32: begin
        word = 1'b1;
        if (word_ok) begin
          op = base_op;
        end
      end
      `EX_OPC_LUI: begin
        op = ALU_PASS_B;
      end
      `EX_OPC_AUIPC: begin
        op     = ALU_ADD;
        sel_pc = 1'b1;  // pc + upper immediate
      end
      `EX_OPC_LOAD,
      `EX_OPC_STORE: begin
        op = ALU_ADD;  // Effective address
      end
      default: begin
        op = ALU_ZERO;
      end
    endcase
  end

endmodule

// ==== rtl/alu_core.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module alu_core (
  input  logic            [`EX_XLEN-1:0] a,
  input  logic            [`EX_XLEN-1:0] b,
  input  ex_pkg::alu_op_e                op,
  input  logic                           word,
  output logic            [`EX_XLEN-1:0] result
);
  import ex_pkg::*;

  logic [`EX_SHAMT_W-1:0]  shamt;
  logic [`EX_SHAMTW_W-1:0] shamt_w;
  logic [31:0]             a_w;
  logic [`EX_XLEN-1:0]     sum;
  logic [`EX_XLEN-1:0]     diff;
  logic                    lt_s;
  logic                    lt_u;
  logic [`EX_XLEN-1:0]     sll_d;
  logic [`EX_XLEN-1:0]     srl_d;
  logic [`EX_XLEN-1:0]     sra_d;
  logic [31:0]             sll_w;
  logic [31:0]             srl_w;
  logic [31:0]             sra_w;
  logic [`EX_XLEN-1:0]     res_full;

  assign shamt   = b[`EX_SHAMT_W-1:0];
  assign shamt_w = b[`EX_SHAMTW_W-1:0];
  assign a_w     = a[31:0];

  assign sum  = a + b;
  assign diff = a - b;
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  assign sll_d = a << shamt;
  assign srl_d = a >> shamt;
  assign sra_d = $unsigned($signed(a) >>> shamt);

  // Word shifts work on the low half only, SRA fills from bit 31
  assign sll_w = a_w << shamt_w;
  assign srl_w = a_w >> shamt_w;
  assign sra_w = $unsigned($signed(a_w) >>> shamt_w);

  always_comb begin
    case (op)
      ALU_ADD:    res_full = sum;
      ALU_SUB:    res_full = diff;
      ALU_SLL:    res_full = word ? {{(`EX_XLEN-32){1'b0}}, sll_w} : sll_d;
      ALU_SLT:    res_full = {{(`EX_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   res_full = {{(`EX_XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    res_full = a ^ b;
      ALU_SRL:    res_full = word ? {{(`EX_XLEN-32){1'b0}}, srl_w} : srl_d;
      ALU_SRA:    res_full = word ? {{(`EX_XLEN-32){1'b0}}, sra_w} : sra_d;
      ALU_OR:     res_full = a | b;
      ALU_AND:    res_full = a & b;
      ALU_PASS_B: res_full = b;
      default:    res_full = '0;
    endcase
  end

  // Upper half is rebuilt from bit 31 for every W instruction
  assign result = word ? {{(`EX_XLEN-32){res_full[31]}}, res_full[31:0]} : res_full;

endmodule

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_stage (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  input  ex_pkg::ex_req_t in_req,
  input  logic            stall,
  input  logic            flush,
  output logic            out_valid,
  output ex_pkg::ex_res_t out_res
);
  import ex_pkg::*;

  logic                q_valid;
  ex_req_t             q_req;
  alu_op_e             op;
  logic                sel_pc;
  logic                word;
  logic [`EX_XLEN-1:0] opa;
  logic [`EX_XLEN-1:0] result;
  ex_res_t             res_d;

  ex_pipe_reg #(.payload_t(ex_req_t)) req_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (in_valid),
    .in_data   (in_req),
    .out_valid (q_valid),
    .out_data  (q_req)
  );

  alu_decode decode0 (
    .opcode    (q_req.opcode),
    .func3     (q_req.func3),
    .func7_b30 (q_req.func7_b30),
    .op        (op),
    .sel_pc    (sel_pc),
    .word      (word)
  );

  assign opa = sel_pc ? q_req.pc : q_req.src1;  // AUIPC adds to the pc

  alu_core alu0 (
    .a      (opa),
    .b      (q_req.src2),
    .op     (op),
    .word   (word),
    .result (result)
  );

  assign res_d = '{result: result, rd: q_req.rd};

  ex_pipe_reg #(.payload_t(ex_res_t)) res_reg (
    .clk       (clk),
    .rst_n     (rst_n),
    .stall     (stall),
    .flush     (flush),
    .in_valid  (q_valid),
    .in_data   (res_d),
    .out_valid (out_valid),
    .out_data  (out_res)
  );

endmodule

// ==== bench/ex_chk.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_chk (
  input logic            clk,
  input logic            rst_n,
  input logic            in_valid,
  input ex_pkg::ex_req_t in_req,
  input logic            stall,
  input logic            flush,
  input logic            out_valid,
  input ex_pkg::ex_res_t out_res
);
  import ex_pkg::*;

  logic    s1_valid;
  ex_req_t s1_req;
  logic    s2_valid;
  ex_res_t s2_res;

  function automatic logic [`EX_XLEN-1:0] sext_w(input logic [31:0] v);
    return {{(`EX_XLEN-32){v[31]}}, v};
  endfunction

  // Expected value taken from the RV64I instruction definitions
  function automatic logic [`EX_XLEN-1:0] isa_result(input ex_req_t r);
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    logic [`EX_XLEN-1:0] res;
    logic [31:0]         w;
    a = r.src1;
    b = r.src2;
    res = '0;
    w = '0;
    case (r.opcode)
      `EX_OPC_OP, `EX_OPC_OP_IMM: begin
        case (r.func3)
          3'd0: begin
            if (r.opcode == `EX_OPC_OP && r.func7_b30) begin
              res = a - b;
            end else begin
              res = a + b;
            end
          end
          3'd1: res = a << b[5:0];
          3'd2: res = {63'b0, $signed(a) < $signed(b)};
          3'd3: res = {63'b0, a < b};
          3'd4: res = a ^ b;
          3'd5: begin
            if (r.func7_b30) begin
              res = $signed(a) >>> b[5:0];  // Fills from bit 63
            end else begin
              res = a >> b[5:0];
            end
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      `EX_OPC_OP_32, `EX_OPC_OP_IMM_32: begin
        if (r.func3 == 3'd0) begin
          if (r.opcode == `EX_OPC_OP_32 && r.func7_b30) begin
            w = a[31:0] - b[31:0];
          end else begin
            w = a[31:0] + b[31:0];
          end
          res = sext_w(w);
        end else if (r.func3 == 3'd1) begin
          w = a[31:0] << b[4:0];
          res = sext_w(w);
        end else if (r.func3 == 3'd5) begin
          if (r.func7_b30) begin
            w = $signed(a[31:0]) >>> b[4:0];
          end else begin
            w = a[31:0] >> b[4:0];
          end
          res = sext_w(w);
        end
      end
      `EX_OPC_LUI:                 res = b;
      `EX_OPC_AUIPC:               res = r.pc + b;
      `EX_OPC_LOAD, `EX_OPC_STORE: res = a + b;
      default:                     res = '0;
    endcase
    return res;
  endfunction

  // Two-slot reference pipeline fed from the DUT ports
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s1_req   <= '0;
      s2_res   <= '0;
    end else if (flush) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else if (!stall) begin
      s1_valid <= in_valid;
      s2_valid <= s1_valid;
      if (in_valid) begin
        s1_req <= in_req;
      end
      if (s1_valid) begin
        s2_res.result <= isa_result(s1_req);
        s2_res.rd     <= s1_req.rd;
      end
    end
  end

  a_reset_low: assert property (@(posedge clk) !rst_n |-> !out_valid)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: out_valid high while in reset", $time);
    end

  a_reset_exit: assert property (@(posedge clk) $rose(rst_n) |=> !out_valid)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: out_valid high in the first cycle after reset", $time);
    end

  a_valid: assert property (@(posedge clk) disable iff (!rst_n) out_valid == s2_valid)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: out_valid is %0b, expected %0b", $time,
             $sampled(out_valid), $sampled(s2_valid));
    end

  a_rd: assert property (@(posedge clk) disable iff (!rst_n)
                         out_valid |-> out_res.rd == s2_res.rd)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: rd is %0d, expected %0d", $time,
             $sampled(out_res.rd), $sampled(s2_res.rd));
    end

  a_result: assert property (@(posedge clk) disable iff (!rst_n)
                             out_valid |-> out_res.result == s2_res.result)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: result is %h, expected %h", $time,
             $sampled(out_res.result), $sampled(s2_res.result));
    end

  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
                                 (stall && !flush) |=> ($stable(out_valid) && $stable(out_res)))
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: output changed across a stalled edge", $time);
    end

  // A flush empties both slots, so nothing from before it shows in the next two cycles
  a_flush_1: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !out_valid)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: out_valid high one cycle after a flush", $time);
    end

  a_flush_2: assert property (@(posedge clk) disable iff (!rst_n)
                              $past(flush) |=> !out_valid)
    else begin
      ex_tb.error_count = ex_tb.error_count + 1;
      $error("Fail %0t: out_valid high two cycles after a flush", $time);
    end

endmodule

// ==== bench/ex_tb.sv ====
`timescale 1ns/1ps
`include "ex_cfg.svh"

module ex_tb;
  import ex_pkg::*;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    in_valid;
  ex_req_t in_req;
  logic    stall;
  logic    flush;
  logic    out_valid;
  ex_res_t out_res;
  int      error_count = 0;

  logic [`EX_XLEN-1:0] corner [8];
  logic [6:0]          opcodes [8];

  always #2 clk = ~clk;

  ex_stage dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .stall     (stall),
    .flush     (flush),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  bind ex_stage ex_chk chk0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .stall     (stall),
    .flush     (flush),
    .out_valid (out_valid),
    .out_res   (out_res)
  );

  function automatic logic [`EX_XLEN-1:0] rand64();
    return {$urandom, $urandom};
  endfunction

  function automatic ex_req_t make_req(input logic [6:0] opc, input logic [2:0] f3,
                                       input logic b30, input logic [`EX_XLEN-1:0] s1,
                                       input logic [`EX_XLEN-1:0] s2);
    ex_req_t r;
    r.opcode    = opc;
    r.func3     = f3;
    r.func7_b30 = b30;
    r.src1      = s1;
    r.src2      = s2;
    r.pc        = rand64();
    r.rd        = 5'($urandom);
    return r;
  endfunction

  task automatic drive(input logic v, input ex_req_t r, input logic st, input logic fl);
    @(posedge clk);
    in_valid <= v;
    in_req   <= r;
    stall    <= st;
    flush    <= fl;
  endtask

  // Pipeline is empty once out_valid has stayed low for three cycles
  task automatic wait_drain(input string phase, input int limit);
    int quiet;
    int cycles;
    quiet  = 0;
    cycles = 0;
    drive(1'b0, '0, 1'b0, 1'b0);
    while (quiet < 3 && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (out_valid) begin
        quiet = 0;
      end else begin
        quiet++;
      end
    end
    if (quiet < 3) begin
      $display("Timeout at %0t: pipeline did not drain after the %s phase", $time, phase);
      error_count++;
    end
  endtask

  initial begin
    logic [6:0] opc;
    void'($urandom(32'h686b));
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_req   = '0;
    stall    = 1'b0;
    flush    = 1'b0;
    corner[0] = '0;
    corner[1] = '1;
    corner[2] = 64'h8000_0000_0000_0000;
    corner[3] = 64'h7fff_ffff_ffff_ffff;
    corner[4] = 64'd31;
    corner[5] = 64'd32;
    corner[6] = 64'd63;
    corner[7] = 64'h0000_0000_8000_0000;  // Sign bit of the word forms
    opcodes[0] = `EX_OPC_OP;
    opcodes[1] = `EX_OPC_OP_IMM;
    opcodes[2] = `EX_OPC_OP_32;
    opcodes[3] = `EX_OPC_OP_IMM_32;
    opcodes[4] = `EX_OPC_LUI;
    opcodes[5] = `EX_OPC_AUIPC;
    opcodes[6] = `EX_OPC_LOAD;
    opcodes[7] = `EX_OPC_STORE;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Every opcode and function pair against all corner operand pairs, back to back
    for (int o = 0; o < 8; o++) begin
      for (int f = 0; f < 8; f++) begin
        for (int b30 = 0; b30 < 2; b30++) begin
          for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
              drive(1'b1, make_req(opcodes[o], 3'(f), 1'(b30), corner[i], corner[j]),
                    1'b0, 1'b0);
            end
          end
        end
      end
    end
    wait_drain("directed", 50);

    for (int n = 0; n < 3000; n++) begin
      if ($urandom % 9 == 8) begin
        opc = 7'($urandom);  // Mostly undefined encodings
      end else begin
        opc = opcodes[$urandom % 8];
      end
      drive(($urandom % 8) != 0, make_req(opc, 3'($urandom), 1'($urandom), rand64(),
            rand64()), 1'b0, 1'b0);
    end
    wait_drain("random", 50);

    for (int n = 0; n < 3000; n++) begin
      opc = opcodes[$urandom % 8];
      drive(($urandom % 4) != 0, make_req(opc, 3'($urandom), 1'($urandom), rand64(),
            rand64()), ($urandom % 4) == 0, ($urandom % 20) == 0);
    end
    wait_drain("stall and flush", 50);

    wait_drain("final", 50);

    $display("Run finished with %0d errors", error_count);
    if (error_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_pipe_reg.sv
rtl/alu_decode.sv
rtl/alu_core.sv
rtl/ex_stage.sv
bench/ex_chk.sv
bench/ex_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps
TOP       ?= ex_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
